//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int instr_w   = 24;
    localparam int opc_w     = 8;
    localparam int opclass_w = 4;

    // Opcode sits above the 16-bit operand field
    localparam int opc_lsb = 16;
    localparam int field_w = 16;

    // Immediates are right-aligned in the operand field
    localparam int imm10_w = 10;
    localparam int imm12_w = 12;
    localparam int imm14_w = 14;
    localparam int imm16_w = 16;

    // Register index positions inside the operand field
    localparam int tgt_gp_lsb = 12;
    localparam int src_gp_lsb = 8;
    localparam int tgt_sr_lsb = 14;
    localparam int src_sr_lsb = 12;

    typedef enum logic [opclass_w-1:0] {
        cls_ur_alu = 4'h0,
        cls_ui_alu = 4'h1,
        cls_sr_alu = 4'h2,
        cls_si_alu = 4'h3,
        cls_ldst   = 4'h4,
        cls_ctrl   = 4'h7,
        cls_cmov   = 4'h8,
        cls_sr_uop = 4'hF
    } opclass_e;

    // Upper nibble is the class, lower nibble the sub-opcode
    typedef enum logic [opc_w-1:0] {
        mov_ur    = 8'h00, add_ur    = 8'h01, sub_ur    = 8'h02, and_ur    = 8'h03,
        or_ur     = 8'h04, xor_ur    = 8'h05, cmp_ur    = 8'h06, not_ur    = 8'h07,
        mov_ui    = 8'h10, add_ui    = 8'h11, sub_ui    = 8'h12, cmp_ui    = 8'h13,
        add_sr    = 8'h20, sub_sr    = 8'h21, neg_sr    = 8'h22, cmp_sr    = 8'h23,
        mov_si    = 8'h30, add_si    = 8'h31, cmp_si    = 8'h32,
        ld_ur     = 8'h40, st_ur     = 8'h41,
        jcc_ur    = 8'h70, jcc_ui    = 8'h71, bcc_sr    = 8'h72, bcc_so    = 8'h73,
        bal_so    = 8'h74,
        mcc_ur    = 8'h80, mcc_si    = 8'h81,
        sr_mov_ur = 8'hF0, sr_add_si = 8'hF1, sr_sub_si = 8'hF2, sr_st_so  = 8'hF3,
        sr_ld_so  = 8'hF4, sr_jcc_so = 8'hF5
    } opcode_e;

endpackage

`default_nettype wire

//--- src/regfile_pkg.sv
`default_nettype none

package regfile_pkg;

    // Sixteen GP registers, four SRs
    localparam int gp_w = 4;
    localparam int sr_w = 2;
    localparam int cc_w = 4;

    typedef logic [gp_w-1:0] gp_idx_t;
    typedef logic [sr_w-1:0] sr_idx_t;
    typedef logic [cc_w-1:0] cc_t;

    // SR2 carries the condition flags
    localparam sr_idx_t sr_flags_idx = sr_idx_t'(2);

endpackage

`default_nettype wire

//--- src/opcode_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_classifier (
    input  isa_pkg::opcode_e opc,
    output logic             sgn_en,
    output logic             imm_en,
    output logic             uses_flags,
    output logic             has_tgt_gp,
    output logic             tgt_gp_we,
    output logic             has_src_gp,
    output logic             has_tgt_sr,
    output logic             tgt_sr_we,
    output logic             has_src_sr
);
    import isa_pkg::*;

    opclass_e opclass;
    // Target field read but not written (cmp, stores)
    logic     tgt_gp_ro;
    logic     tgt_sr_ro;
    logic     sr_src_own;

    assign opclass = opclass_e'(opc[opc_w-1 -: opclass_w]);

    always_comb begin
        sgn_en     = 1'b0;
        imm_en     = 1'b0;
        uses_flags = 1'b0;
        tgt_gp_we  = 1'b0;
        tgt_gp_ro  = 1'b0;
        has_src_gp = 1'b0;
        tgt_sr_we  = 1'b0;
        tgt_sr_ro  = 1'b0;
        sr_src_own = 1'b0;
        case (opclass)
            cls_ur_alu, cls_sr_alu: begin
                sgn_en = (opclass == cls_sr_alu);
                case (opc)
                    mov_ur, add_ur, sub_ur, and_ur, or_ur, xor_ur, add_sr, sub_sr: begin
                        tgt_gp_we  = 1'b1;
                        has_src_gp = 1'b1;
                    end
                    cmp_ur, cmp_sr: begin
                        tgt_gp_ro  = 1'b1;
                        has_src_gp = 1'b1;
                    end
                    not_ur, neg_sr: tgt_gp_we = 1'b1;
                    // Hole in the class table
                    default: sgn_en = 1'b0;
                endcase
            end
            cls_ui_alu, cls_si_alu: begin
                case (opc)
                    mov_ui, add_ui, sub_ui, mov_si, add_si: begin
                        imm_en    = 1'b1;
                        tgt_gp_we = 1'b1;
                    end
                    cmp_ui, cmp_si: begin
                        imm_en    = 1'b1;
                        tgt_gp_ro = 1'b1;
                    end
                    default: ;
                endcase
                sgn_en = imm_en && (opclass == cls_si_alu);
            end
            cls_ldst: begin
                case (opc)
                    ld_ur: tgt_gp_we = 1'b1;
                    st_ur: tgt_gp_ro = 1'b1;
                    default: ;
                endcase
                has_src_gp = tgt_gp_we || tgt_gp_ro;
            end
            cls_ctrl: begin
                case (opc)
                    jcc_ur: uses_flags = 1'b1;
                    jcc_ui: begin
                        uses_flags = 1'b1;
                        imm_en     = 1'b1;
                    end
                    bcc_sr: begin
                        uses_flags = 1'b1;
                        sgn_en     = 1'b1;
                        has_src_gp = 1'b1;
                    end
                    bcc_so, bal_so: begin
                        uses_flags = 1'b1;
                        sgn_en     = 1'b1;
                        imm_en     = 1'b1;
                    end
                    default: ;
                endcase
            end
            cls_cmov: begin
                case (opc)
                    mcc_ur: has_src_gp = 1'b1;
                    default: ;
                endcase
                uses_flags = (opc == mcc_ur) || (opc == mcc_si);
                tgt_gp_we  = uses_flags;
            end
            cls_sr_uop: begin
                case (opc)
                    sr_mov_ur: begin
                        tgt_sr_we  = 1'b1;
                        sr_src_own = 1'b1;
                    end
                    sr_add_si, sr_sub_si: tgt_sr_we = 1'b1;
                    sr_st_so: begin
                        tgt_sr_ro  = 1'b1;
                        sr_src_own = 1'b1;
                    end
                    sr_ld_so: begin
                        tgt_sr_we  = 1'b1;
                        sr_src_own = 1'b1;
                    end
                    sr_jcc_so: begin
                        uses_flags = 1'b1;
                        sr_src_own = 1'b1;
                    end
                    default: ;
                endcase
                // Every defined SR micro-op but the move carries a signed offset
                imm_en = (tgt_sr_we || tgt_sr_ro || uses_flags) && (opc != sr_mov_ur);
                sgn_en = imm_en;
            end
            default: ;
        endcase
    end

    assign has_tgt_gp = tgt_gp_we || tgt_gp_ro;
    assign has_tgt_sr = tgt_sr_we || tgt_sr_ro;
    assign has_src_sr = sr_src_own || uses_flags;

endmodule

`default_nettype wire

//--- src/operand_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module operand_extractor (
    input  isa_pkg::opcode_e                  opc,
    input  logic [isa_pkg::field_w-1:0]       field,
    input  logic                              has_tgt_gp,
    input  logic                              has_src_gp,
    input  logic                              has_tgt_sr,
    input  logic                              has_src_sr,
    input  logic                              uses_flags,
    output logic [isa_pkg::imm10_w-1:0]       imm10,
    output logic [isa_pkg::imm12_w-1:0]       imm12,
    output logic [isa_pkg::imm14_w-1:0]       imm14,
    output logic [isa_pkg::imm16_w-1:0]       imm16,
    output regfile_pkg::cc_t                  cc,
    output regfile_pkg::gp_idx_t              tgt_gp,
    output regfile_pkg::gp_idx_t              src_gp,
    output regfile_pkg::sr_idx_t              tgt_sr,
    output regfile_pkg::sr_idx_t              src_sr
);
    import isa_pkg::*;
    import regfile_pkg::*;

    // At most one immediate is live per opcode
    always_comb begin
        imm10 = '0;
        imm12 = '0;
        imm14 = '0;
        imm16 = '0;
        case (opc)
            mov_ui, add_ui, sub_ui, cmp_ui,
            mov_si, add_si, cmp_si,
            jcc_ui, bcc_so,
            sr_st_so, sr_ld_so: begin
                imm12 = field[imm12_w-1:0];
            end
            sr_add_si, sr_sub_si: begin
                imm14 = field[imm14_w-1:0];
            end
            sr_jcc_so: begin
                imm10 = field[imm10_w-1:0];
            end
            bal_so: begin
                imm16 = field[imm16_w-1:0];
            end
            default: ;
        endcase
    end

    // Condition code position depends on the encoding
    always_comb begin
        case (opc)
            jcc_ur, sr_jcc_so: begin
                cc = field[13:10];
            end
            jcc_ui, bcc_so: begin
                cc = field[15:12];
            end
            bcc_sr, mcc_si: begin
                cc = field[11:8];
            end
            mcc_ur: begin
                cc = field[7:4];
            end
            default: begin
                cc = '0;
            end
        endcase
    end

    assign tgt_gp = has_tgt_gp ? field[tgt_gp_lsb +: gp_w] : '0;
    assign src_gp = has_src_gp ? field[src_gp_lsb +: gp_w] : '0;
    assign tgt_sr = has_tgt_sr ? field[tgt_sr_lsb +: sr_w] : '0;

    // Flag consumers read the flags SR implicitly
    always_comb begin
        if (!has_src_sr) begin
            src_sr = '0;
        end else if (uses_flags) begin
            src_sr = sr_flags_idx;
        end else begin
            src_sr = field[src_sr_lsb +: sr_w];
        end
    end

endmodule

`default_nettype wire

//--- src/id_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_reg #(
    parameter int ADDR_W = 16
) (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          flush,
    input  logic                          stall,
    input  logic [ADDR_W-1:0]             d_pc,
    input  isa_pkg::opcode_e              d_opc,
    input  logic                          d_sgn_en,
    input  logic                          d_imm_en,
    input  logic [isa_pkg::imm10_w-1:0]   d_imm10,
    input  logic [isa_pkg::imm12_w-1:0]   d_imm12,
    input  logic [isa_pkg::imm14_w-1:0]   d_imm14,
    input  logic [isa_pkg::imm16_w-1:0]   d_imm16,
    input  regfile_pkg::cc_t              d_cc,
    input  logic                          d_has_src_gp,
    input  regfile_pkg::gp_idx_t          d_src_gp,
    input  regfile_pkg::gp_idx_t          d_tgt_gp,
    input  logic                          d_tgt_gp_we,
    input  logic                          d_has_src_sr,
    input  regfile_pkg::sr_idx_t          d_src_sr,
    input  regfile_pkg::sr_idx_t          d_tgt_sr,
    input  logic                          d_tgt_sr_we,
    output logic [ADDR_W-1:0]             pc,
    output isa_pkg::opcode_e              opc,
    output logic                          sgn_en,
    output logic                          imm_en,
    output logic [isa_pkg::imm10_w-1:0]   imm10,
    output logic [isa_pkg::imm12_w-1:0]   imm12,
    output logic [isa_pkg::imm14_w-1:0]   imm14,
    output logic [isa_pkg::imm16_w-1:0]   imm16,
    output regfile_pkg::cc_t              cc,
    output logic                          has_src_gp,
    output regfile_pkg::gp_idx_t          src_gp,
    output regfile_pkg::gp_idx_t          tgt_gp,
    output logic                          tgt_gp_we,
    output logic                          has_src_sr,
    output regfile_pkg::sr_idx_t          src_sr,
    output regfile_pkg::sr_idx_t          tgt_sr,
    output logic                          tgt_sr_we
);
    import isa_pkg::*;

    localparam opcode_e opc_clear = opcode_e'(opc_w'(0));

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc         <= '0;
            opc        <= opc_clear;
            sgn_en     <= 1'b0;
            imm_en     <= 1'b0;
            imm10      <= '0;
            imm12      <= '0;
            imm14      <= '0;
            imm16      <= '0;
            cc         <= '0;
            has_src_gp <= 1'b0;
            src_gp     <= '0;
            tgt_gp     <= '0;
            tgt_gp_we  <= 1'b0;
            has_src_sr <= 1'b0;
            src_sr     <= '0;
            tgt_sr     <= '0;
            tgt_sr_we  <= 1'b0;
        end else if (flush || !stall) begin
            // Flush loads a bubble, even under stall
            pc         <= flush ? '0 : d_pc;
            opc        <= flush ? opc_clear : d_opc;
            sgn_en     <= !flush && d_sgn_en;
            imm_en     <= !flush && d_imm_en;
            imm10      <= flush ? '0 : d_imm10;
            imm12      <= flush ? '0 : d_imm12;
            imm14      <= flush ? '0 : d_imm14;
            imm16      <= flush ? '0 : d_imm16;
            cc         <= flush ? '0 : d_cc;
            has_src_gp <= !flush && d_has_src_gp;
            src_gp     <= flush ? '0 : d_src_gp;
            tgt_gp     <= flush ? '0 : d_tgt_gp;
            tgt_gp_we  <= !flush && d_tgt_gp_we;
            has_src_sr <= !flush && d_has_src_sr;
            src_sr     <= flush ? '0 : d_src_sr;
            tgt_sr     <= flush ? '0 : d_tgt_sr;
            tgt_sr_we  <= !flush && d_tgt_sr_we;
        end
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
    parameter int ADDR_W = 16
) (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          flush,
    input  logic                          stall,
    input  logic [isa_pkg::instr_w-1:0]   instr,
    input  logic [ADDR_W-1:0]             pc,
    output logic [ADDR_W-1:0]             pc_out,
    output isa_pkg::opcode_e              opc,
    output logic                          sgn_en,
    output logic                          imm_en,
    output logic [isa_pkg::imm10_w-1:0]   imm10,
    output logic [isa_pkg::imm12_w-1:0]   imm12,
    output logic [isa_pkg::imm14_w-1:0]   imm14,
    output logic [isa_pkg::imm16_w-1:0]   imm16,
    output regfile_pkg::cc_t              cc,
    output logic                          has_src_gp,
    output regfile_pkg::gp_idx_t          src_gp,
    output regfile_pkg::gp_idx_t          tgt_gp,
    output logic                          tgt_gp_we,
    output logic                          has_src_sr,
    output regfile_pkg::sr_idx_t          src_sr,
    output regfile_pkg::sr_idx_t          tgt_sr,
    output logic                          tgt_sr_we
);
    import isa_pkg::*;
    import regfile_pkg::*;

    opcode_e              dec_opc;
    logic [field_w-1:0]   dec_field;
    logic                 dec_sgn_en;
    logic                 dec_imm_en;
    logic                 dec_uses_flags;
    logic                 dec_has_tgt_gp;
    logic                 dec_tgt_gp_we;
    logic                 dec_has_src_gp;
    logic                 dec_has_tgt_sr;
    logic                 dec_tgt_sr_we;
    logic                 dec_has_src_sr;
    logic [imm10_w-1:0]   dec_imm10;
    logic [imm12_w-1:0]   dec_imm12;
    logic [imm14_w-1:0]   dec_imm14;
    logic [imm16_w-1:0]   dec_imm16;
    cc_t                  dec_cc;
    gp_idx_t              dec_tgt_gp;
    gp_idx_t              dec_src_gp;
    sr_idx_t              dec_tgt_sr;
    sr_idx_t              dec_src_sr;

    // Opcode on top, operand field below
    assign dec_opc   = opcode_e'(instr[opc_lsb +: opc_w]);
    assign dec_field = instr[field_w-1:0];

    opcode_classifier classifier_inst (
        .opc        (dec_opc),
        .sgn_en     (dec_sgn_en),
        .imm_en     (dec_imm_en),
        .uses_flags (dec_uses_flags),
        .has_tgt_gp (dec_has_tgt_gp),
        .tgt_gp_we  (dec_tgt_gp_we),
        .has_src_gp (dec_has_src_gp),
        .has_tgt_sr (dec_has_tgt_sr),
        .tgt_sr_we  (dec_tgt_sr_we),
        .has_src_sr (dec_has_src_sr)
    );

    operand_extractor extractor_inst (
        .opc        (dec_opc),
        .field      (dec_field),
        .has_tgt_gp (dec_has_tgt_gp),
        .has_src_gp (dec_has_src_gp),
        .has_tgt_sr (dec_has_tgt_sr),
        .has_src_sr (dec_has_src_sr),
        .uses_flags (dec_uses_flags),
        .imm10      (dec_imm10),
        .imm12      (dec_imm12),
        .imm14      (dec_imm14),
        .imm16      (dec_imm16),
        .cc         (dec_cc),
        .tgt_gp     (dec_tgt_gp),
        .src_gp     (dec_src_gp),
        .tgt_sr     (dec_tgt_sr),
        .src_sr     (dec_src_sr)
    );

    id_stage_reg #(
        .ADDR_W (ADDR_W)
    ) stage_reg_inst (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .flush        (flush),
        .stall        (stall),
        .d_pc         (pc),
        .d_opc        (dec_opc),
        .d_sgn_en     (dec_sgn_en),
        .d_imm_en     (dec_imm_en),
        .d_imm10      (dec_imm10),
        .d_imm12      (dec_imm12),
        .d_imm14      (dec_imm14),
        .d_imm16      (dec_imm16),
        .d_cc         (dec_cc),
        .d_has_src_gp (dec_has_src_gp),
        .d_src_gp     (dec_src_gp),
        .d_tgt_gp     (dec_tgt_gp),
        .d_tgt_gp_we  (dec_tgt_gp_we),
        .d_has_src_sr (dec_has_src_sr),
        .d_src_sr     (dec_src_sr),
        .d_tgt_sr     (dec_tgt_sr),
        .d_tgt_sr_we  (dec_tgt_sr_we),
        .pc           (pc_out),
        .opc          (opc),
        .sgn_en       (sgn_en),
        .imm_en       (imm_en),
        .imm10        (imm10),
        .imm12        (imm12),
        .imm14        (imm14),
        .imm16        (imm16),
        .cc           (cc),
        .has_src_gp   (has_src_gp),
        .src_gp       (src_gp),
        .tgt_gp       (tgt_gp),
        .tgt_gp_we    (tgt_gp_we),
        .has_src_sr   (has_src_sr),
        .src_sr       (src_sr),
        .tgt_sr       (tgt_sr),
        .tgt_sr_we    (tgt_sr_we)
    );

endmodule

`default_nettype wire

//--- tests/id_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions #(
    parameter int ADDR_W = 16
) (
    input logic                          iw_clk,
    input logic                          iw_rst,
    input logic                          flush,
    input logic                          stall,
    input logic [ADDR_W-1:0]             pc_out,
    input logic [isa_pkg::opc_w-1:0]     opc,
    input logic                          sgn_en,
    input logic                          imm_en,
    input logic [isa_pkg::imm10_w-1:0]   imm10,
    input logic [isa_pkg::imm12_w-1:0]   imm12,
    input logic [isa_pkg::imm14_w-1:0]   imm14,
    input logic [isa_pkg::imm16_w-1:0]   imm16,
    input regfile_pkg::cc_t              cc,
    input logic                          has_src_gp,
    input regfile_pkg::gp_idx_t          src_gp,
    input regfile_pkg::gp_idx_t          tgt_gp,
    input logic                          tgt_gp_we,
    input logic                          has_src_sr,
    input regfile_pkg::sr_idx_t          src_sr,
    input regfile_pkg::sr_idx_t          tgt_sr,
    input logic                          tgt_sr_we
);
    import isa_pkg::*;
    import regfile_pkg::*;

    localparam int snap_w = ADDR_W + opc_w + imm10_w + imm12_w + imm14_w + imm16_w + 22;

    // Every registered output in one vector
    logic [snap_w-1:0] snapshot;

    assign snapshot = {pc_out, opc, sgn_en, imm_en, imm10, imm12, imm14, imm16, cc,
                       has_src_gp, src_gp, tgt_gp, tgt_gp_we,
                       has_src_sr, src_sr, tgt_sr, tgt_sr_we};

    flush_clears_outputs: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> !(sgn_en || imm_en || has_src_gp || tgt_gp_we || has_src_sr || tgt_sr_we)
                  && src_gp == '0 && tgt_gp == '0 && src_sr == '0 && tgt_sr == '0)
        else $error("flush did not clear the enables and indices");

    // Flush takes priority, so only a lone stall freezes the register
    stall_holds_outputs: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable(snapshot))
        else $error("outputs changed under stall");

    reset_blocks_writes: assert property (@(posedge iw_clk)
        iw_rst |-> (!tgt_gp_we && !tgt_sr_we))
        else $error("write enable active during reset");

endmodule

bind id_stage id_stage_assertions #(.ADDR_W(ADDR_W)) assertions_inst (.*);

`default_nettype wire

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import isa_pkg::*;
    import regfile_pkg::*;

    localparam int addr_w = 16;

    // Flags are {sgn_en, imm_en, has_src_gp, tgt_gp_we, has_src_sr, tgt_sr_we}
    typedef struct packed {
        logic [instr_w-1:0] instr;
        logic               flush;
        logic               stall;
        logic [opc_w-1:0]   opc;
        logic [5:0]         flags;
        logic [imm10_w-1:0] imm10;
        logic [imm12_w-1:0] imm12;
        logic [imm14_w-1:0] imm14;
        logic [imm16_w-1:0] imm16;
        cc_t                cc;
        gp_idx_t            src_gp;
        gp_idx_t            tgt_gp;
        sr_idx_t            src_sr;
        sr_idx_t            tgt_sr;
    } row_t;

    logic                iw_clk;
    logic                iw_rst;
    logic                flush;
    logic                stall;
    logic [instr_w-1:0]  instr;
    logic [addr_w-1:0]   pc;
    logic [addr_w-1:0]   pc_out;
    opcode_e             opc;
    logic                sgn_en;
    logic                imm_en;
    logic [imm10_w-1:0]  imm10;
    logic [imm12_w-1:0]  imm12;
    logic [imm14_w-1:0]  imm14;
    logic [imm16_w-1:0]  imm16;
    cc_t                 cc;
    logic                has_src_gp;
    gp_idx_t             src_gp;
    gp_idx_t             tgt_gp;
    logic                tgt_gp_we;
    logic                has_src_sr;
    sr_idx_t             src_sr;
    sr_idx_t             tgt_sr;
    logic                tgt_sr_we;

    row_t                rows[$];
    string               names[$];
    logic [addr_w-1:0]   exp_pc[$];

    id_stage #(
        .ADDR_W (addr_w)
    ) id_stage_inst (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .flush      (flush),
        .stall      (stall),
        .instr      (instr),
        .pc         (pc),
        .pc_out     (pc_out),
        .opc        (opc),
        .sgn_en     (sgn_en),
        .imm_en     (imm_en),
        .imm10      (imm10),
        .imm12      (imm12),
        .imm14      (imm14),
        .imm16      (imm16),
        .cc         (cc),
        .has_src_gp (has_src_gp),
        .src_gp     (src_gp),
        .tgt_gp     (tgt_gp),
        .tgt_gp_we  (tgt_gp_we),
        .has_src_sr (has_src_sr),
        .src_sr     (src_sr),
        .tgt_sr     (tgt_sr),
        .tgt_sr_we  (tgt_sr_we)
    );

    initial iw_clk = 1'b0;
    always #50 iw_clk = ~iw_clk;

    // Reset spans the first two rising edges
    initial begin
        repeat (2) @(posedge iw_clk);
        iw_rst <= 1'b0;
    end

    task automatic add_row(input string name, input logic [instr_w-1:0] word,
                           input logic fl, input logic st, input logic [opc_w-1:0] op,
                           input logic [5:0] fv, input logic [imm10_w-1:0] i10,
                           input logic [imm12_w-1:0] i12, input logic [imm14_w-1:0] i14,
                           input logic [imm16_w-1:0] i16, input cc_t cv,
                           input gp_idx_t sgp, input gp_idx_t tgp,
                           input sr_idx_t ssr, input sr_idx_t tsr);
        row_t r;
        r.instr  = word;
        r.flush  = fl;
        r.stall  = st;
        r.opc    = op;
        r.flags  = fv;
        r.imm10  = i10;
        r.imm12  = i12;
        r.imm14  = i14;
        r.imm16  = i16;
        r.cc     = cv;
        r.src_gp = sgp;
        r.tgt_gp = tgp;
        r.src_sr = ssr;
        r.tgt_sr = tsr;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Columns: name, instr, flush, stall, opc, flags, imm10, imm12, imm14, imm16,
    // cc, src_gp, tgt_gp, src_sr, tgt_sr
    task automatic load_table();
        add_row("add_ur", 24'h01_5A30, 1'b0, 1'b0, 8'h01, 6'b001100,
                '0, '0, '0, '0, 4'h0, 4'hA, 4'h5, 2'd0, 2'd0);
        add_row("not_ur", 24'h07_3C00, 1'b0, 1'b0, 8'h07, 6'b000100,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h3, 2'd0, 2'd0);
        add_row("cmp_ur", 24'h06_7200, 1'b0, 1'b0, 8'h06, 6'b001000,
                '0, '0, '0, '0, 4'h0, 4'h2, 4'h7, 2'd0, 2'd0);
        add_row("add_ui", 24'h11_4ABC, 1'b0, 1'b0, 8'h11, 6'b010100,
                '0, 12'hABC, '0, '0, 4'h0, 4'h0, 4'h4, 2'd0, 2'd0);
        add_row("cmp_ui", 24'h13_9123, 1'b0, 1'b0, 8'h13, 6'b010000,
                '0, 12'h123, '0, '0, 4'h0, 4'h0, 4'h9, 2'd0, 2'd0);
        add_row("sub_sr", 24'h21_2F77, 1'b0, 1'b0, 8'h21, 6'b101100,
                '0, '0, '0, '0, 4'h0, 4'hF, 4'h2, 2'd0, 2'd0);
        add_row("neg_sr", 24'h22_E456, 1'b0, 1'b0, 8'h22, 6'b100100,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'hE, 2'd0, 2'd0);
        add_row("add_si", 24'h31_6F80, 1'b0, 1'b0, 8'h31, 6'b110100,
                '0, 12'hF80, '0, '0, 4'h0, 4'h0, 4'h6, 2'd0, 2'd0);
        add_row("cmp_si", 24'h32_1800, 1'b0, 1'b0, 8'h32, 6'b110000,
                '0, 12'h800, '0, '0, 4'h0, 4'h0, 4'h1, 2'd0, 2'd0);
        add_row("ld_ur", 24'h40_8B00, 1'b0, 1'b0, 8'h40, 6'b001100,
                '0, '0, '0, '0, 4'h0, 4'hB, 4'h8, 2'd0, 2'd0);
        add_row("st_ur", 24'h41_C3FF, 1'b0, 1'b0, 8'h41, 6'b001000,
                '0, '0, '0, '0, 4'h0, 4'h3, 4'hC, 2'd0, 2'd0);
        add_row("mcc_ur", 24'h80_35A0, 1'b0, 1'b0, 8'h80, 6'b001110,
                '0, '0, '0, '0, 4'hA, 4'h5, 4'h3, 2'd2, 2'd0);
        add_row("mcc_si", 24'h81_D700, 1'b0, 1'b0, 8'h81, 6'b000110,
                '0, '0, '0, '0, 4'h7, 4'h0, 4'hD, 2'd2, 2'd0);
        add_row("jcc_ur", 24'h70_2C00, 1'b0, 1'b0, 8'h70, 6'b000010,
                '0, '0, '0, '0, 4'hB, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("jcc_ui", 24'h71_9456, 1'b0, 1'b0, 8'h71, 6'b010010,
                '0, 12'h456, '0, '0, 4'h9, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("bcc_sr", 24'h72_0E40, 1'b0, 1'b0, 8'h72, 6'b101010,
                '0, '0, '0, '0, 4'hE, 4'hE, 4'h0, 2'd2, 2'd0);
        add_row("bcc_so", 24'h73_5321, 1'b0, 1'b0, 8'h73, 6'b110010,
                '0, 12'h321, '0, '0, 4'h5, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("bal_so", 24'h74_BEEF, 1'b0, 1'b0, 8'h74, 6'b110010,
                '0, '0, '0, 16'hBEEF, 4'h0, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("sr_mov_ur", 24'hF0_D000, 1'b0, 1'b0, 8'hF0, 6'b000011,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd1, 2'd3);
        add_row("sr_add_si", 24'hF1_7ABC, 1'b0, 1'b0, 8'hF1, 6'b110001,
                '0, '0, 14'h3ABC, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd1);
        add_row("sr_sub_si", 24'hF2_C001, 1'b0, 1'b0, 8'hF2, 6'b110001,
                '0, '0, 14'h0001, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd3);
        add_row("sr_st_so", 24'hF3_B123, 1'b0, 1'b0, 8'hF3, 6'b110010,
                '0, 12'h123, '0, '0, 4'h0, 4'h0, 4'h0, 2'd3, 2'd2);
        add_row("sr_ld_so", 24'hF4_6FED, 1'b0, 1'b0, 8'hF4, 6'b110011,
                '0, 12'hFED, '0, '0, 4'h0, 4'h0, 4'h0, 2'd2, 2'd1);
        add_row("sr_jcc_so", 24'hF5_3BFF, 1'b0, 1'b0, 8'hF5, 6'b110010,
                10'h3FF, '0, '0, '0, 4'hE, 4'h0, 4'h0, 2'd2, 2'd0);
        // Stalled rows keep the sr_jcc_so result
        add_row("stall_a", 24'h01_1234, 1'b0, 1'b1, 8'hF5, 6'b110010,
                10'h3FF, '0, '0, '0, 4'hE, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("stall_b", 24'h40_8B00, 1'b0, 1'b1, 8'hF5, 6'b110010,
                10'h3FF, '0, '0, '0, 4'hE, 4'h0, 4'h0, 2'd2, 2'd0);
        add_row("flush_stall", 24'h01_5A30, 1'b1, 1'b1, 8'h00, 6'b000000,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd0);
        add_row("undef_5a", 24'h5A_FFFF, 1'b0, 1'b0, 8'h5A, 6'b000000,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd0);
        add_row("hole_08", 24'h08_FFFF, 1'b0, 1'b0, 8'h08, 6'b000000,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd0);
        add_row("hole_f7", 24'hF7_FFFF, 1'b0, 1'b0, 8'hF7, 6'b000000,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd0);
        add_row("flush", 24'h11_4ABC, 1'b1, 1'b0, 8'h00, 6'b000000,
                '0, '0, '0, '0, 4'h0, 4'h0, 4'h0, 2'd0, 2'd0);
        add_row("xor_ur", 24'h05_1200, 1'b0, 1'b0, 8'h05, 6'b001100,
                '0, '0, '0, '0, 4'h0, 4'h2, 4'h1, 2'd0, 2'd0);
    endtask

    task automatic expect_equal(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "decode output mismatch");
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic compare_outputs(input string tag, input row_t r,
                                   input logic [addr_w-1:0] pc_exp);
        expect_equal({tag, " pc_out"}, 32'(pc_exp), 32'(pc_out));
        expect_equal({tag, " opc"}, 32'(r.opc), 32'(opc));
        expect_equal({tag, " sgn_en"}, 32'(r.flags[5]), 32'(sgn_en));
        expect_equal({tag, " imm_en"}, 32'(r.flags[4]), 32'(imm_en));
        expect_equal({tag, " has_src_gp"}, 32'(r.flags[3]), 32'(has_src_gp));
        expect_equal({tag, " tgt_gp_we"}, 32'(r.flags[2]), 32'(tgt_gp_we));
        expect_equal({tag, " has_src_sr"}, 32'(r.flags[1]), 32'(has_src_sr));
        expect_equal({tag, " tgt_sr_we"}, 32'(r.flags[0]), 32'(tgt_sr_we));
        expect_equal({tag, " imm10"}, 32'(r.imm10), 32'(imm10));
        expect_equal({tag, " imm12"}, 32'(r.imm12), 32'(imm12));
        expect_equal({tag, " imm14"}, 32'(r.imm14), 32'(imm14));
        expect_equal({tag, " imm16"}, 32'(r.imm16), 32'(imm16));
        expect_equal({tag, " cc"}, 32'(r.cc), 32'(cc));
        expect_equal({tag, " src_gp"}, 32'(r.src_gp), 32'(src_gp));
        expect_equal({tag, " tgt_gp"}, 32'(r.tgt_gp), 32'(tgt_gp));
        expect_equal({tag, " src_sr"}, 32'(r.src_sr), 32'(src_sr));
        expect_equal({tag, " tgt_sr"}, 32'(r.tgt_sr), 32'(tgt_sr));
    endtask

    initial begin
        int                i;
        int                cycles;
        logic [addr_w-1:0] pc_val;
        logic [addr_w-1:0] prev_pc;
        row_t              zero_row;

        iw_rst   = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        instr    = '0;
        pc       = '0;
        prev_pc  = '0;
        zero_row = '0;
        void'($urandom(84));
        load_table();

        cycles = 0;
        while (iw_rst && cycles < 10) begin
            @(negedge iw_clk);
            cycles++;
        end
        if (iw_rst) begin
            abort("Reset was never released");
        end
        compare_outputs("reset", zero_row, '0);

        // Row i goes in on this edge, row i-1 is visible after it
        for (i = 0; i < rows.size(); i++) begin
            @(posedge iw_clk);
            pc_val = addr_w'($urandom());
            instr <= rows[i].instr;
            pc    <= pc_val;
            flush <= rows[i].flush;
            stall <= rows[i].stall;
            if (rows[i].flush) begin
                exp_pc.push_back('0);
            end else if (rows[i].stall) begin
                exp_pc.push_back(prev_pc);
            end else begin
                exp_pc.push_back(pc_val);
            end
            prev_pc = exp_pc[i];
            @(negedge iw_clk);
            if (i > 0) begin
                compare_outputs(names[i-1], rows[i-1], exp_pc[i-1]);
            end
        end

        @(posedge iw_clk);
        flush <= 1'b0;
        stall <= 1'b1;
        @(negedge iw_clk);
        compare_outputs(names[rows.size()-1], rows[rows.size()-1], exp_pc[rows.size()-1]);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/isa_pkg.sv
src/regfile_pkg.sv
src/opcode_classifier.sv
src/operand_extractor.sv
src/id_stage_reg.sv
src/id_stage.sv
tests/id_stage_assertions.sv
tests/tb_id_stage.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_id_stage
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
